// File: dv/tb_soc_axi.sv
//##########################################################################
// testbench for the axi memory subsystem top
// clock, reset, watchdog, compare task, bus tasks and directed tests
// a reference model of the sram contents gives the expected read data
//##########################################################################

`include "soc_defines.svh"

module tb_soc_axi import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int N_TESTS    = 5;
	localparam int MAX_BEATS  = 8;
	localparam int MARGIN     = 40;	// cycles allowed per beat

	logic		clock;
	logic		rst_n_i;
	axi_addr_t	ar_i, aw_i;
	logic		ar_valid_i, ar_ready_o;
	axi_r_t		r_o;
	logic		r_valid_o, r_ready_i;
	logic		aw_valid_i, aw_ready_o;
	axi_w_t		w_i;
	logic		w_valid_i, w_ready_o;
	axi_b_t		b_o;
	logic		b_valid_o, b_ready_i;

	logic [31:0]	model [`SRAM_DEPTH];	// expected sram contents
	logic [31:0]	wdata_buf [MAX_BEATS];	// beats of the next write burst
	logic [31:0]	rdata_q [$];		// beats of the last read burst
	int		known_word;		// word written with a known value

	soc_axi_top dut (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(N_TESTS * MAX_BEATS * MARGIN * CLK_PERIOD);
		$display("run timed out before all tests finished");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s, got %0h expected %0h",
				$time, msg, got, exp);
			$display("Done: errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic send_ar(input logic [31:0] start_addr, input logic [3:0] id,
			input logic [7:0] len);
		@(posedge clock);
		ar_i <= '{addr: start_addr, id: id, len: len, size: 3'd2, burst: INCR};
		ar_valid_i <= 1'b1;
		do @(negedge clock); while (!ar_ready_o);
		@(posedge clock);	// ar handshake
		ar_valid_i <= 1'b0;
	endtask

	task automatic send_aw(input logic [31:0] start_addr, input logic [3:0] id,
			input logic [7:0] len);
		@(posedge clock);
		aw_i <= '{addr: start_addr, id: id, len: len, size: 3'd2, burst: INCR};
		aw_valid_i <= 1'b1;
		do @(negedge clock); while (!aw_ready_o);
		@(posedge clock);	// aw handshake
		aw_valid_i <= 1'b0;
	endtask

	// write wdata_buf[0..len] from a word index and take the b response
	task automatic write_burst(input int word, input logic [3:0] id, input int len,
			input logic [3:0] strb);
		int idx;
		send_aw(32'(word * 4), id, 8'(len));
		for (int k = 0; k <= len; k++) begin
			w_i <= '{data: wdata_buf[k], strb: strb, last: (k == len)};
			w_valid_i <= 1'b1;
			do @(negedge clock); while (!w_ready_o);
			@(posedge clock);
			idx = (word + k) % `SRAM_DEPTH;	// incr burst wraps in the array
			for (int i = 0; i < 4; i++) begin
				if (strb[i]) model[idx][8*i +: 8] = wdata_buf[k][8*i +: 8];
			end
		end
		w_valid_i <= 1'b0;
		b_ready_i <= 1'b1;
		do @(negedge clock); while (!b_valid_o);
		check_eq(64'(b_o.resp), 64'(OKAY), "write response code");
		check_eq(64'(b_o.id), 64'(id), "write response id");
		@(posedge clock);
		b_ready_i <= 1'b0;
	endtask

	// collect a read burst into rdata_q with optional random r_ready stalls
	task automatic read_burst(input logic [31:0] start_addr, input logic [3:0] id,
			input int len, input bit stall);
		int k;
		bit done;
		rdata_q.delete();
		k = 0;
		done = 1'b0;
		send_ar(start_addr, id, 8'(len));
		r_ready_i <= stall ? 1'($urandom()) : 1'b1;
		while (!done) begin
			@(negedge clock);
			if (r_valid_o && r_ready_i) begin
				rdata_q.push_back(r_o.data);
				check_eq(64'(r_o.resp), 64'(OKAY), "read response code");
				check_eq(64'(r_o.id), 64'(id), "read response id");
				check_eq(64'(r_o.last), 64'(k == len), "read last flag");
				done = r_o.last;
				k++;
			end
			@(posedge clock);
			if (done) r_ready_i <= 1'b0;
			else r_ready_i <= stall ? 1'($urandom()) : 1'b1;
		end
	endtask

	task automatic test_single_rw();
		int word;
		logic [3:0] id;
		word = int'($urandom() % `SRAM_DEPTH);
		id = 4'($urandom());
		wdata_buf[0] = $urandom();
		write_burst(word, id, 0, 4'hf);
		read_burst(32'(word * 4), ~id, 0, 1'b0);
		check_eq(64'(rdata_q[0]), 64'(wdata_buf[0]), "single word read-back");
	endtask

	task automatic test_burst_rw();
		int word;
		logic [3:0] id;
		word = int'($urandom() % `SRAM_DEPTH);
		id = 4'($urandom());
		for (int k = 0; k < 4; k++) wdata_buf[k] = $urandom();
		write_burst(word, id, 3, 4'hf);
		read_burst(32'(word * 4), ~id, 3, 1'b0);
		check_eq(64'(rdata_q.size()), 64'd4, "burst beat count");
		for (int k = 0; k < 4; k++) begin
			check_eq(64'(rdata_q[k]), 64'(model[(word + k) % `SRAM_DEPTH]),
				"burst beat data");
		end
	endtask

	task automatic test_strobes();
		int word;
		logic [3:0] id;
		logic [3:0] strb;
		logic [31:0] old_word;
		logic [31:0] exp;
		word = int'($urandom() % `SRAM_DEPTH);
		id = 4'($urandom());
		old_word = 32'ha5a5_5a5a;
		wdata_buf[0] = old_word;
		write_burst(word, id, 0, 4'hf);
		wdata_buf[0] = $urandom();
		strb = 4'($urandom() % 14 + 1);	// never 0 or f
		write_burst(word, id, 0, strb);
		for (int i = 0; i < 4; i++) begin
			exp[8*i +: 8] = strb[i] ? wdata_buf[0][8*i +: 8] : old_word[8*i +: 8];
		end
		read_burst(32'(word * 4), id, 0, 1'b0);
		check_eq(64'(rdata_q[0]), 64'(exp), "byte strobe merge");
	endtask

	task automatic test_backpressure();
		int word;
		logic [3:0] id;
		word = int'($urandom() % `SRAM_DEPTH);
		id = 4'($urandom());
		for (int k = 0; k < 8; k++) wdata_buf[k] = $urandom();
		write_burst(word, id, 7, 4'hf);
		known_word = word;
		read_burst(32'(word * 4), id, 7, 1'b1);
		check_eq(64'(rdata_q.size()), 64'd8, "beat count under stalls");
		for (int k = 0; k < 8; k++) begin
			check_eq(64'(rdata_q[k]), 64'(model[(word + k) % `SRAM_DEPTH]),
				"stalled beat data");
		end
	endtask

	task automatic test_clint();
		logic [3:0] id;
		logic [31:0] first;
		id = 4'($urandom());
		read_burst(`CLINT_BASE | `MTIME_LO_OFS, id, 0, 1'b0);
		first = rdata_q[0];
		repeat (10) @(posedge clock);
		read_burst(`CLINT_BASE | `MTIME_LO_OFS, ~id, 0, 1'b0);
		check_eq(64'(rdata_q[0] > first), 64'd1, "mtime advances");
		// crossbar must have released the clint
		read_burst(32'(known_word * 4), id, 0, 1'b0);
		check_eq(64'(rdata_q[0]), 64'(model[known_word]), "sram read after clint");
	endtask

	initial begin
		void'($urandom(13258));
		rst_n_i = 1'b0;
		ar_i = '0;
		ar_valid_i = 1'b0;
		aw_i = '0;
		aw_valid_i = 1'b0;
		w_i = '0;
		w_valid_i = 1'b0;
		r_ready_i = 1'b0;
		b_ready_i = 1'b0;
		known_word = 0;
		repeat (4) @(posedge clock);
		rst_n_i <= 1'b1;

		test_single_rw();
		test_burst_rw();
		test_strobes();
		test_backpressure();
		test_clint();

		repeat (2) @(posedge clock);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_soc_axi -o tb_soc_axi_sim

# the exit status of the run is not used, the log decides
./obj_dir/tb_soc_axi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

// File: sim.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/soc_burst_cnt.sv
verilog/soc_sram_mem.sv
verilog/soc_sram_ctrl.sv
verilog/soc_axi_xbar.sv
verilog/soc_clint.sv
verilog/soc_axi_top.sv
dv/tb_soc_axi.sv

// File: verilog/soc_axi_top.sv
//##########################################################################
// memory subsystem top, read crossbar with sram and clint slaves
// writes go straight to the sram controller
//##########################################################################

module soc_axi_top import soc_pkg::*; (
	input  logic		clock,
	input  logic		rst_n_i,
	input  axi_addr_t	ar_i,
	input  logic		ar_valid_i,
	output logic		ar_ready_o,
	output axi_r_t		r_o,
	output logic		r_valid_o,
	input  logic		r_ready_i,
	input  axi_addr_t	aw_i,
	input  logic		aw_valid_i,
	output logic		aw_ready_o,
	input  axi_w_t		w_i,
	input  logic		w_valid_i,
	output logic		w_ready_o,
	output axi_b_t		b_o,
	output logic		b_valid_o,
	input  logic		b_ready_i
);

	axi_addr_t	sram_ar, clint_ar;
	logic		sram_ar_valid, sram_ar_ready;
	logic		clint_ar_valid, clint_ar_ready;
	axi_r_t		sram_r, clint_r;
	logic		sram_r_valid, sram_r_ready;
	logic		clint_r_valid, clint_r_ready;

	soc_axi_xbar u_xbar (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.ar_i             (ar_i),
		.ar_valid_i       (ar_valid_i),
		.ar_ready_o       (ar_ready_o),
		.r_o              (r_o),
		.r_valid_o        (r_valid_o),
		.r_ready_i        (r_ready_i),
		.sram_ar_o        (sram_ar),
		.sram_ar_valid_o  (sram_ar_valid),
		.sram_ar_ready_i  (sram_ar_ready),
		.sram_r_i         (sram_r),
		.sram_r_valid_i   (sram_r_valid),
		.sram_r_ready_o   (sram_r_ready),
		.clint_ar_o       (clint_ar),
		.clint_ar_valid_o (clint_ar_valid),
		.clint_ar_ready_i (clint_ar_ready),
		.clint_r_i        (clint_r),
		.clint_r_valid_i  (clint_r_valid),
		.clint_r_ready_o  (clint_r_ready)
	);

	soc_sram_ctrl u_sram (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.ar_i       (sram_ar),
		.ar_valid_i (sram_ar_valid),
		.ar_ready_o (sram_ar_ready),
		.r_o        (sram_r),
		.r_valid_o  (sram_r_valid),
		.r_ready_i  (sram_r_ready),
		.aw_i       (aw_i),	// write path bypasses the crossbar
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.w_i        (w_i),
		.w_valid_i  (w_valid_i),
		.w_ready_o  (w_ready_o),
		.b_o        (b_o),
		.b_valid_o  (b_valid_o),
		.b_ready_i  (b_ready_i)
	);

	soc_clint u_clint (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.ar_i       (clint_ar),
		.ar_valid_i (clint_ar_valid),
		.ar_ready_o (clint_ar_ready),
		.r_o        (clint_r),
		.r_valid_o  (clint_r_valid),
		.r_ready_i  (clint_r_ready)
	);

endmodule

// File: verilog/soc_axi_xbar.sv
//##########################################################################
// read crossbar, steers ar to sram or clint by address
// holds the device choice until the last r beat
//##########################################################################

`include "soc_defines.svh"

module soc_axi_xbar import soc_pkg::*; (
	input  logic		clock,
	input  logic		rst_n_i,

	input  axi_addr_t	ar_i,
	input  logic		ar_valid_i,
	output logic		ar_ready_o,
	output axi_r_t		r_o,
	output logic		r_valid_o,
	input  logic		r_ready_i,

	output axi_addr_t	sram_ar_o,
	output logic		sram_ar_valid_o,
	input  logic		sram_ar_ready_i,
	input  axi_r_t		sram_r_i,
	input  logic		sram_r_valid_i,
	output logic		sram_r_ready_o,

	output axi_addr_t	clint_ar_o,
	output logic		clint_ar_valid_o,
	input  logic		clint_ar_ready_i,
	input  axi_r_t		clint_r_i,
	input  logic		clint_r_valid_i,
	output logic		clint_r_ready_o
);

	xbar_dev_e	dev_dec;	// decoded from the current ar
	xbar_dev_e	dev_q;		// held until the last r beat
	logic		busy_q;		// a read is open
	logic		ar_hs;
	logic		r_hs;

	assign dev_dec = ((ar_i.addr & ~`CLINT_MASK) == `CLINT_BASE) ? DEV_CLINT : DEV_SRAM;

	assign sram_ar_o  = ar_i;
	assign clint_ar_o = ar_i;

	// only one slave sees the request, and none while a read is open
	assign sram_ar_valid_o  = ar_valid_i && !busy_q && (dev_dec == DEV_SRAM);
	assign clint_ar_valid_o = ar_valid_i && !busy_q && (dev_dec == DEV_CLINT);
	assign ar_ready_o = !busy_q &&
		((dev_dec == DEV_CLINT) ? clint_ar_ready_i : sram_ar_ready_i);

	// response path follows the held device
	assign r_o       = (dev_q == DEV_CLINT) ? clint_r_i : sram_r_i;
	assign r_valid_o = busy_q && ((dev_q == DEV_CLINT) ? clint_r_valid_i : sram_r_valid_i);
	assign sram_r_ready_o  = busy_q && (dev_q == DEV_SRAM) && r_ready_i;
	assign clint_r_ready_o = busy_q && (dev_q == DEV_CLINT) && r_ready_i;

	assign ar_hs = ar_valid_i && ar_ready_o;
	assign r_hs  = r_valid_o && r_ready_i;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			dev_q  <= DEV_SRAM;
		end else if (ar_hs) begin
			busy_q <= 1'b1;
			dev_q  <= dev_dec;	// latch the choice
		end else if (r_hs && r_o.last) begin
			busy_q <= 1'b0;	// release after the last beat
		end
	end

	// a slave only answers while it holds the crossbar
	a_no_stray_r: assert property (@(posedge clock) disable iff (!rst_n_i)
		!(sram_r_valid_i && !(busy_q && dev_q == DEV_SRAM)) &&
		!(clint_r_valid_i && !(busy_q && dev_q == DEV_CLINT)));

endmodule

// File: verilog/soc_burst_cnt.sv
//##########################################################################
// burst beat counter with last-beat flag
//##########################################################################

module soc_burst_cnt (
	input  logic		clock,
	input  logic		rst_n_i,
	input  logic		start_i,	// new burst accepted
	input  logic		step_i,		// one beat transferred
	input  logic [7:0]	len_i,		// latched burst length
	output logic [7:0]	beat_o,
	output logic		last_o
);

	logic [7:0] beat_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			beat_q <= '0;
		end else if (start_i) begin
			beat_q <= '0;
		end else if (step_i) begin
			beat_q <= beat_q + 8'd1;
		end
	end

	assign beat_o = beat_q;
	assign last_o = (beat_q == len_i);	// len counts beats minus one

endmodule

// File: verilog/soc_clint.sv
//##########################################################################
// clint with a free-running 64-bit mtime
// single-beat read slave for the mtime words
//##########################################################################

`include "soc_defines.svh"

module soc_clint import soc_pkg::*; (
	input  logic		clock,
	input  logic		rst_n_i,
	input  axi_addr_t	ar_i,
	input  logic		ar_valid_i,
	output logic		ar_ready_o,
	output axi_r_t		r_o,
	output logic		r_valid_o,
	input  logic		r_ready_i
);

	logic [63:0]		mtime_q;
	logic			r_valid_q;
	logic [`ID_LEN-1:0]	id_q;
	logic [`DATA_LEN-1:0]	data_q;
	logic [`DATA_LEN-1:0]	rd_word;
	logic [`ADDR_LEN-1:0]	ofs;
	logic			ar_hs;

	assign ofs   = ar_i.addr & `CLINT_MASK;	// offset inside the window
	assign ar_ready_o = !r_valid_q;	// one response at a time
	assign ar_hs = ar_valid_i && ar_ready_o;

	always_comb begin
		case (ofs)
			`MTIME_LO_OFS: rd_word = mtime_q[31:0];
			`MTIME_HI_OFS: rd_word = mtime_q[63:32];
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q   <= '0;
			r_valid_q <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 64'd1;
			if (ar_hs) r_valid_q <= 1'b1;
			else if (r_ready_i) r_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			id_q   <= ar_i.id;
			data_q <= rd_word;	// sampled at the request
		end
	end

	assign r_valid_o = r_valid_q;
	always_comb begin
		r_o.data = data_q;
		r_o.resp = OKAY;
		r_o.last = r_valid_q;	// every read is a single beat
		r_o.id   = id_q;
	end

	a_single_beat: assert property (@(posedge clock) disable iff (!rst_n_i)
		ar_hs |-> (ar_i.len == 8'd0));

endmodule

// File: verilog/soc_defines.svh
//##########################################################################
// bus widths, id width and sram depth
// clint address window and mtime register offsets
//##########################################################################

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define ADDR_LEN	32
`define DATA_LEN	32
`define ID_LEN		4

// on-chip sram, in words
`define SRAM_DEPTH	256

// clint window, everything outside it goes to the sram
`define CLINT_BASE	32'h0200_0000
`define CLINT_MASK	32'h0000_ffff	// 64 KiB window

// mtime offsets inside the clint window
`define MTIME_LO_OFS	32'h0000_bff8
`define MTIME_HI_OFS	32'h0000_bffc

`endif

// File: verilog/soc_pkg.sv
//##########################################################################
// axi channel payload structs
// response, burst, device select and sram state enums
//##########################################################################

`include "soc_defines.svh"

package soc_pkg;

	typedef enum logic [1:0] {
		OKAY	= 2'b00,
		SLVERR	= 2'b10	// never produced here
	} axi_resp_e;

	typedef enum logic [1:0] {
		FIXED	= 2'b00,
		INCR	= 2'b01,	// the only accepted type
		WRAP	= 2'b10
	} axi_burst_e;

	typedef enum logic {
		DEV_SRAM,
		DEV_CLINT
	} xbar_dev_e;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE,
		RESP
	} sram_state_e;

	typedef logic [$clog2(`SRAM_DEPTH)-1:0] sram_addr_t;	// sram word index

	typedef struct packed {
		logic [`ADDR_LEN-1:0]	addr;
		logic [`ID_LEN-1:0]	id;
		logic [7:0]		len;	// beats minus one
		logic [2:0]		size;
		axi_burst_e		burst;
	} axi_addr_t;

	typedef struct packed {
		logic [`DATA_LEN-1:0]	data;
		axi_resp_e		resp;
		logic			last;
		logic [`ID_LEN-1:0]	id;
	} axi_r_t;

	typedef struct packed {
		logic [`DATA_LEN-1:0]	data;
		logic [`DATA_LEN/8-1:0]	strb;
		logic			last;
	} axi_w_t;

	typedef struct packed {
		axi_resp_e		resp;
		logic [`ID_LEN-1:0]	id;
	} axi_b_t;

endpackage

// File: verilog/soc_sram_ctrl.sv
//##########################################################################
// sram slave FSM serving one read or write burst at a time
// drives the beat counter and the word array
//##########################################################################

`include "soc_defines.svh"

module soc_sram_ctrl import soc_pkg::*; (
	input  logic		clock,
	input  logic		rst_n_i,
	input  axi_addr_t	ar_i,
	input  logic		ar_valid_i,
	output logic		ar_ready_o,
	output axi_r_t		r_o,
	output logic		r_valid_o,
	input  logic		r_ready_i,
	input  axi_addr_t	aw_i,
	input  logic		aw_valid_i,
	output logic		aw_ready_o,
	input  axi_w_t		w_i,
	input  logic		w_valid_i,
	output logic		w_ready_o,
	output axi_b_t		b_o,
	output logic		b_valid_o,
	input  logic		b_ready_i
);

	sram_state_e		state_q, state_d;
	axi_addr_t		req;		// request being accepted
	logic [`ID_LEN-1:0]	id_q;
	sram_addr_t		base_q;		// start word index
	logic [7:0]		len_q;
	logic [7:0]		beat;
	logic			last;
	logic			ar_hs, aw_hs, r_hs, w_hs;
	sram_addr_t		cur_addr, next_addr, raddr;
	logic [`DATA_LEN-1:0]	rdata;

	assign ar_ready_o = (state_q == IDLE);
	assign aw_ready_o = (state_q == IDLE) && !ar_valid_i;	// reads win
	assign w_ready_o  = (state_q == WRITE);
	assign r_valid_o  = (state_q == READ);
	assign b_valid_o  = (state_q == RESP);

	assign ar_hs = ar_valid_i && ar_ready_o;
	assign aw_hs = aw_valid_i && aw_ready_o;
	assign r_hs  = r_valid_o && r_ready_i;
	assign w_hs  = w_valid_i && w_ready_o;

	assign req = ar_valid_i ? ar_i : aw_i;

	// word address of the current beat wraps in the array
	assign cur_addr  = base_q + sram_addr_t'(beat);
	assign next_addr = cur_addr + sram_addr_t'(1);
	assign raddr = (state_q == IDLE) ? sram_addr_t'(ar_i.addr >> 2) :
		(r_hs ? next_addr : cur_addr);	// hold address under back-pressure

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (ar_hs) state_d = READ;
				else if (aw_hs) state_d = WRITE;
			end
			READ:  if (r_hs && last) state_d = IDLE;
			WRITE: if (w_hs && last) state_d = RESP;
			RESP:  if (b_ready_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) state_q <= IDLE;
		else state_q <= state_d;
	end

	always_ff @(posedge clock) begin
		if (ar_hs || aw_hs) begin
			id_q   <= req.id;
			base_q <= sram_addr_t'(req.addr >> 2);
			len_q  <= req.len;
		end
	end

	always_comb begin
		r_o.data = rdata;
		r_o.resp = OKAY;
		r_o.last = last && (state_q == READ);
		r_o.id   = id_q;
		b_o.resp = OKAY;
		b_o.id   = id_q;
	end

	soc_burst_cnt u_cnt (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.start_i (ar_hs || aw_hs),
		.step_i  (r_hs || w_hs),
		.len_i   (len_q),
		.beat_o  (beat),
		.last_o  (last)
	);

	soc_sram_mem u_mem (
		.clock   (clock),
		.we_i    (w_hs),
		.waddr_i (cur_addr),
		.wdata_i (w_i.data),
		.wstrb_i (w_i.strb),
		.raddr_i (raddr),
		.rdata_o (rdata)
	);

	a_incr_only: assert property (@(posedge clock) disable iff (!rst_n_i)
		(!ar_hs || ar_i.burst == INCR) && (!aw_hs || aw_i.burst == INCR));
	a_wlast_match: assert property (@(posedge clock) disable iff (!rst_n_i)
		w_hs |-> (w_i.last == last));	// master and counter agree on burst end
	a_r_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		(r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)));

endmodule

// File: verilog/soc_sram_mem.sv
//##########################################################################
// sram word array, byte-strobe write and registered read
//##########################################################################

`include "soc_defines.svh"

module soc_sram_mem import soc_pkg::*; (
	input  logic			clock,
	input  logic			we_i,
	input  sram_addr_t		waddr_i,
	input  logic [`DATA_LEN-1:0]	wdata_i,
	input  logic [`DATA_LEN/8-1:0]	wstrb_i,
	input  sram_addr_t		raddr_i,
	output logic [`DATA_LEN-1:0]	rdata_o
);

	logic [`DATA_LEN-1:0] mem [`SRAM_DEPTH];

	always_ff @(posedge clock) begin
		if (we_i) begin
			for (int i = 0; i < `DATA_LEN/8; i++) begin
				if (wstrb_i[i]) mem[waddr_i][8*i +: 8] <= wdata_i[8*i +: 8];	// strobed bytes only
			end
		end
		rdata_o <= mem[raddr_i];	// one cycle read latency
	end

endmodule
